//--- include/bpl_config.svh
// bitplane fetch constants
`ifndef BPL_CONFIG_SVH
`define BPL_CONFIG_SVH

// ------------------------------------------------
// custom register byte offsets
// ------------------------------------------------
`define BPL_DIWSTRT    9'h08E // display window start
`define BPL_DIWSTOP    9'h090 // display window stop
`define BPL_DIWHIGH    9'h1E4 // ecs window high bits
`define BPL_DDFSTRT    9'h092 // data fetch start
`define BPL_DDFSTOP    9'h094 // data fetch stop
`define BPL_BPL1MOD    9'h108 // odd plane modulo
`define BPL_BPL2MOD    9'h10A // even plane modulo
`define BPL_BPLCON0    9'h100 // bitplane control 0
`define BPL_BPLPTBASE  9'h0E0 // first plane pointer, 4 bytes per plane
`define BPL_BPL1DAT    8'h88  // word address of plane 1 data

// hardware fetch window limits, in CCKs
`define BPL_HARD_START 8'h18
`define BPL_HARD_STOP  8'hD8
`define BPL_HPOS_LAST  9'd455  // last half-CCK of a line
`define BPL_VPOS_LAST  11'd312 // last line of a frame
`endif

//--- rtl/bpl_pkg.sv
// bitplane fetch types
package bpl_pkg;

  // custom register word address, bits 8:1 of the byte offset
  typedef logic [7:0] reg_addr_t;

  // chip memory word address
  typedef logic [19:0] chip_addr_t;

  typedef logic [15:0] word_t; // bus data word

  // beam positions
  typedef logic [8:0]  hpos_t; // half-CCK units
  typedef logic [10:0] vpos_t; // lines

  typedef logic [2:0] plane_t; // plane index, 0 is BPL1

  // fetch sequencer
  typedef enum logic [1:0] {
    FETCH_IDLE, // nothing fetched
    FETCH_RUN,  // inside the fetch window
    FETCH_LAST  // closing sequence, modulo is added
  } fetch_state_t;

endpackage

//--- rtl/beam_counter.sv
// beam position counter
`timescale 1ns/1ns
`include "bpl_config.svh"

module beam_counter (
  input  logic           clk,
  input  logic           reset,
  input  logic           clk7_en,
  output bpl_pkg::hpos_t hpos,
  output bpl_pkg::vpos_t vpos,
  output logic           sof
);

  bpl_pkg::hpos_t hpos_q;
  bpl_pkg::vpos_t vpos_q;
  logic           line_end;  // last half-CCK of the line
  logic           frame_end; // last half-CCK of the frame

  assign line_end  = (hpos_q == `BPL_HPOS_LAST);
  assign frame_end = line_end && (vpos_q == `BPL_VPOS_LAST);

  // horizontal count, one step per enabled cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      hpos_q <= '0;
    end else if (clk7_en) begin
      hpos_q <= line_end ? '0 : hpos_q + 1'b1;
    end
  end

  // vertical count steps on the line wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      vpos_q <= '0;
      sof    <= 1'b0;
    end else if (clk7_en) begin
      if (line_end) begin
        vpos_q <= frame_end ? '0 : vpos_q + 1'b1;
      end
      sof <= frame_end; // high for the first enabled cycle of the frame
    end
  end

  assign hpos = hpos_q;
  assign vpos = vpos_q;

  // the line never runs past its last count
  a_hpos_range: assert property (@(posedge clk) disable iff (reset)
    hpos_q <= `BPL_HPOS_LAST);

endmodule

//--- rtl/bitplane_dma.sv
// bitplane dma engine
`timescale 1ns/1ns
`include "bpl_config.svh"

module bitplane_dma (
  input  logic                clk,
  input  logic                clk7_en,
  input  logic                reset,
  input  logic                ecs,     // ecs window and fetch bits
  input  logic                a1k,     // no display start on line 0
  input  logic                sof,
  input  logic                dmaena,
  input  bpl_pkg::vpos_t      vpos,
  input  bpl_pkg::hpos_t      hpos,
  input  bpl_pkg::reg_addr_t  reg_address_in,
  input  bpl_pkg::word_t      data_in,
  output logic                dma,
  output bpl_pkg::reg_addr_t  reg_address_out,
  output bpl_pkg::chip_addr_t address_out
);

  logic [8:0]            reg_byte;      // byte offset of the bus write
  logic                  sel_ddfstrt;
  logic                  sel_pt;        // pointer register range
  bpl_pkg::vpos_t        vdiwstrt;
  bpl_pkg::vpos_t        vdiwstop;
  logic                  vdiwena;       // vertical window open
  logic [6:0]            ddfstrt;       // bits 8:2
  logic [6:0]            ddfstop;
  logic [14:0]           bpl1mod;       // word modulo, odd planes
  logic [14:0]           bpl2mod;       // even planes
  logic [4:0]            bplcon0;       // shres, hires, bpu
  logic [4:0]            bplcon0_d0;
  logic [4:0]            bplcon0_d1;
  logic [4:0]            bplcon0_dly;   // 3 CCKs late
  logic [1:0]            dmaena_dly;    // 2 and 4 CCKs late
  logic                  shres;
  logic                  hires;
  bpl_pkg::plane_t       planes;        // planes actually fetched
  logic                  soft_start;
  logic                  soft_stop;
  logic                  hard_start;
  logic                  hard_stop;
  logic                  softena;       // ddfstrt..ddfstop
  logic                  hardena;       // $18..$D8
  logic                  ddfena_0;
  logic                  ddfena;        // window, 2 CCKs late
  bpl_pkg::fetch_state_t state;
  logic [2:0]            seq;           // slot within the 8 CCK sequence
  logic                  add_mod;
  bpl_pkg::plane_t       plane;
  bpl_pkg::plane_t       ptr_sel;
  logic [4:0]            bplpth [8];    // pointer high parts
  logic [14:0]           bplptl [8];    // pointer low parts
  logic [14:0]           mod_sel;
  bpl_pkg::chip_addr_t   newpt;

  assign reg_byte    = {reg_address_in, 1'b0};
  assign sel_ddfstrt = (reg_byte == `BPL_DDFSTRT);
  assign sel_pt      = ({reg_address_in[7:4], 5'b0_0000} == `BPL_BPLPTBASE);

  // ------------------------------------------------
  // register bank
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (clk7_en) begin
      if (reg_byte == `BPL_DIWSTRT) begin
        vdiwstrt <= {3'b000, data_in[15:8]}; // writing DIWSTRT clears V10-V8
      end else if (reg_byte == `BPL_DIWHIGH && ecs) begin
        vdiwstrt[10:8] <= data_in[2:0];
      end
      if (reg_byte == `BPL_DIWSTOP) begin
        vdiwstop <= {2'b00, ~data_in[15], data_in[15:8]}; // V8 is ~V7
      end else if (reg_byte == `BPL_DIWHIGH && ecs) begin
        vdiwstop[10:8] <= data_in[10:8];
      end
      if (sel_ddfstrt)                 ddfstrt <= data_in[7:1];
      if (reg_byte == `BPL_DDFSTOP)    ddfstop <= data_in[7:1];
      if (reg_byte == `BPL_BPL1MOD)    bpl1mod <= data_in[15:1];
      if (reg_byte == `BPL_BPL2MOD)    bpl2mod <= data_in[15:1];
    end
  end

  // bplcon0 and dmaena pipelines, the display chip sees them late
  always_ff @(posedge clk) begin
    if (reset) begin
      bplcon0     <= '0;
      bplcon0_d0  <= '0;
      bplcon0_d1  <= '0;
      bplcon0_dly <= '0;
      dmaena_dly  <= '0;
    end else if (clk7_en) begin
      if (reg_byte == `BPL_BPLCON0) begin
        bplcon0 <= {data_in[6], data_in[15], data_in[14:12]};
      end
      if (hpos[0]) begin // one stage per CCK
        bplcon0_d0  <= bplcon0;
        bplcon0_d1  <= bplcon0_d0;
        bplcon0_dly <= bplcon0_d1;
      end
      if (hpos[1:0] == 2'b11) dmaena_dly <= {dmaena_dly[0], dmaena}; // every 2 CCKs
    end
  end

  assign shres  = ecs & bplcon0_dly[4];
  assign hires  = bplcon0_dly[3];
  assign planes = (bplcon0_dly[2:0] == 3'b111) ? 3'd4 : bplcon0_dly[2:0];

  // ------------------------------------------------
  // windows
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      vdiwena <= 1'b0;
    end else if (clk7_en) begin
      if ((sof && !a1k) || (vpos == '0 && a1k) || vpos == vdiwstop) begin
        vdiwena <= 1'b0;
      end else if (vpos == vdiwstrt) begin
        vdiwena <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      {soft_start, soft_stop, hard_start, hard_stop} <= 4'b0000;
      {softena, hardena, ddfena_0, ddfena}           <= 4'b0000;
    end else if (clk7_en && hpos[0]) begin
      soft_start <= (hpos[8:1] == {ddfstrt[6:1], ddfstrt[0] & ecs, 1'b0});
      soft_stop  <= (hpos[8:1] == {ddfstop[6:1], ddfstop[0] & ecs, 1'b0});
      hard_start <= (hpos[8:1] == `BPL_HARD_START);
      hard_stop  <= (hpos[8:1] == `BPL_HARD_STOP);
      // ocs only starts inside the vertical window, a DDFSTRT write blocks it
      if (soft_start && (ecs || (vdiwena && dmaena)) && !sel_ddfstrt) begin
        softena <= 1'b1;
      end else if (soft_stop || (!ecs && hard_stop)) begin
        softena <= 1'b0;
      end
      if (hard_start)     hardena <= 1'b1;
      else if (hard_stop) hardena <= 1'b0;
      ddfena_0 <= hardena & softena;
      ddfena   <= ddfena_0;
    end
  end

  // ------------------------------------------------
  // fetch sequencer
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= bpl_pkg::FETCH_IDLE;
      seq   <= 3'd0;
    end else if (clk7_en && hpos[0]) begin
      seq <= (state == bpl_pkg::FETCH_IDLE) ? 3'd0 : seq + 3'd1;
      case (state)
        bpl_pkg::FETCH_IDLE: begin
          // sequences start on a 2-CCK boundary
          if (ddfena && vdiwena && !hpos[1] && dmaena_dly[0]) state <= bpl_pkg::FETCH_RUN;
        end
        bpl_pkg::FETCH_RUN: begin
          if (seq == 3'd7) begin
            if (!vdiwena)     state <= bpl_pkg::FETCH_IDLE;
            else if (!ddfena) state <= bpl_pkg::FETCH_LAST; // window closed, one more
          end
        end
        default: begin
          if (seq == 3'd7) state <= bpl_pkg::FETCH_IDLE;
        end
      endcase
    end
  end

  // slot to plane, lowres 8 slots, hires 4, shres 2
  always_comb begin
    if (shres)      plane = {2'b00, ~seq[0]};
    else if (hires) plane = {1'b0, ~seq[0], ~seq[1]};
    else            plane = {~seq[0], ~seq[1], ~seq[2]};
  end

  // modulo only on the last pass over each plane
  assign add_mod = (state == bpl_pkg::FETCH_LAST) &&
                   (shres ? &seq[2:1] : (hires ? seq[2] : 1'b1));

  assign dma = (state != bpl_pkg::FETCH_IDLE) && dmaena_dly[1] && hpos[0] && (plane < planes);

  // ------------------------------------------------
  // pointers
  // ------------------------------------------------
  assign ptr_sel = dma ? plane : reg_address_in[3:1]; // dma slot owns the write port

  always_ff @(posedge clk) begin
    if (clk7_en) begin
      if (dma || (sel_pt && !reg_address_in[0])) begin
        bplpth[ptr_sel] <= dma ? newpt[19:15] : data_in[4:0];
      end
      if (dma || (sel_pt && reg_address_in[0])) begin
        bplptl[ptr_sel] <= dma ? newpt[14:0] : data_in[15:1];
      end
    end
  end

  assign address_out = {bplpth[plane], bplptl[plane]};

  assign mod_sel = plane[0] ? bpl2mod : bpl1mod; // index 0 is BPL1, odd
  assign newpt   = address_out + (add_mod ? {{5{mod_sel[14]}}, mod_sel} : 20'd0) + 20'd1;

  assign reg_address_out = `BPL_BPL1DAT + {5'b0_0000, plane};

  // a slot is followed by an even position, so the next enabled cycle has no dma
  a_dma_odd: assert property (@(posedge clk) disable iff (reset)
    (clk7_en && dma) |=> (!dma throughout (clk7_en [->1])));
  // planes 7 and 8 are never fetched
  a_dma_plane: assert property (@(posedge clk) disable iff (reset)
    (clk7_en && dma) |-> (reg_address_out < (`BPL_BPL1DAT + 8'd6)));

endmodule

//--- rtl/bitplane_latch.sv
// bitplane data latch
`timescale 1ns/1ns
`include "bpl_config.svh"

module bitplane_latch (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clk7_en,
  input  logic                    dma,
  input  bpl_pkg::reg_addr_t      reg_address_out,
  input  bpl_pkg::word_t          chip_data_in,
  output bpl_pkg::word_t [5:0]    bpl_data,
  output logic                    bpl_load
);

  bpl_pkg::reg_addr_t   plane_ofs; // offset from BPL1DAT
  bpl_pkg::plane_t      plane_idx;
  logic                 plane_hit; // one of the six fetched planes
  bpl_pkg::word_t [5:0] plane_q;   // BPLxDAT holding registers
  logic                 load_arm;  // plane 1 just stored

  assign plane_ofs = reg_address_out - `BPL_BPL1DAT;
  assign plane_idx = plane_ofs[2:0];
  assign plane_hit = (plane_ofs < 8'd6); // 7 and 8 are aga only

  // ------------------------------------------------
  // per-plane data registers
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (clk7_en && dma && plane_hit) begin
      plane_q[plane_idx] <= chip_data_in;
    end
  end

  // plane 1 is fetched last, so its store triggers the load
  always_ff @(posedge clk) begin
    if (reset) begin
      load_arm <= 1'b0;
      bpl_load <= 1'b0;
    end else begin
      load_arm <= clk7_en && dma && (reg_address_out == `BPL_BPL1DAT);
      bpl_load <= load_arm; // one clk, not one enabled cycle
    end
  end

  // parallel copy for the shifters
  always_ff @(posedge clk) begin
    if (load_arm) begin
      bpl_data <= plane_q;
    end
  end

  a_load_single: assert property (@(posedge clk) disable iff (reset)
    bpl_load |=> !bpl_load);

endmodule

//--- rtl/bitplane_fetch_top.sv
// bitplane fetch subsystem
`timescale 1ns/1ns

module bitplane_fetch_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk7_en,
  input  logic                ecs,
  input  logic                a1k,
  input  logic                dmaena,
  input  bpl_pkg::reg_addr_t  reg_address_in,
  input  bpl_pkg::word_t      data_in,
  input  bpl_pkg::word_t      chip_data_in,  // valid with dma
  output logic                dma,
  output bpl_pkg::chip_addr_t address_out,
  output bpl_pkg::reg_addr_t  reg_address_out,
  output bpl_pkg::hpos_t      hpos,
  output bpl_pkg::vpos_t      vpos,
  output bpl_pkg::word_t [5:0] bpl_data,
  output logic                bpl_load
);

  logic sof; // frame start, beam counter to dma engine

  beam_counter i_beam_counter (
    .clk     (clk),
    .reset   (reset),
    .clk7_en (clk7_en),
    .hpos    (hpos),
    .vpos    (vpos),
    .sof     (sof)
  );

  bitplane_dma i_bitplane_dma (
    .clk (clk), .clk7_en (clk7_en), .reset (reset),
    .ecs (ecs), .a1k (a1k), .sof (sof), .dmaena (dmaena),
    .vpos (vpos), .hpos (hpos),
    .reg_address_in (reg_address_in), .data_in (data_in),
    .dma (dma), .reg_address_out (reg_address_out), .address_out (address_out)
  );

  bitplane_latch i_bitplane_latch (
    .clk (clk), .reset (reset), .clk7_en (clk7_en), .dma (dma),
    .reg_address_out (reg_address_out), .chip_data_in (chip_data_in),
    .bpl_data (bpl_data), .bpl_load (bpl_load)
  );

endmodule

//--- tb/tb_bitplane_fetch.sv
// bitplane fetch testbench
`timescale 1ns/1ns
`include "bpl_config.svh"

module tb_bitplane_fetch;

  localparam int line_timeout  = 2000;   // clk cycles, a line takes 912
  localparam int frame_timeout = 300000; // a frame takes about 285k

  logic                 clk;
  logic                 reset;
  logic                 clk7_en;
  logic                 ecs;
  logic                 a1k;
  logic                 dmaena;
  bpl_pkg::reg_addr_t   reg_address_in;
  bpl_pkg::word_t       data_in;
  bpl_pkg::word_t       chip_data_in;
  logic                 dma;
  bpl_pkg::chip_addr_t  address_out;
  bpl_pkg::reg_addr_t   reg_address_out;
  bpl_pkg::hpos_t       hpos;
  bpl_pkg::vpos_t       vpos;
  bpl_pkg::word_t [5:0] bpl_data;
  logic                 bpl_load;

  logic [31:0]          seed;
  logic [31:0]          phase;          // clock enable phase
  int                   nplanes;        // planes enabled in BPLCON0
  int                   load_count;     // bpl_load pulses over the run
  int                   line_loads;     // bpl_load pulses on the scanned line
  bpl_pkg::chip_addr_t  last_addr [6];  // latest dma address per plane
  bpl_pkg::chip_addr_t  slot_addr [$];  // dma slots of the scanned line
  int                   slot_plane [$];

  bitplane_fetch_top i_bitplane_fetch_top (
    .clk (clk), .reset (reset), .clk7_en (clk7_en),
    .ecs (ecs), .a1k (a1k), .dmaena (dmaena),
    .reg_address_in (reg_address_in), .data_in (data_in), .chip_data_in (chip_data_in),
    .dma (dma), .address_out (address_out), .reg_address_out (reg_address_out),
    .hpos (hpos), .vpos (vpos), .bpl_data (bpl_data), .bpl_load (bpl_load)
  );

  // chip memory model, data follows the address
  assign chip_data_in = dma ? (address_out[15:0] ^ 16'hA5A5) : 16'h0000;

  always #50 clk = ~clk;

  always @(posedge clk) begin
    #10 clk7_en = ~clk7_en; // enabled on alternate cycles
  end

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string test, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s expected %0h actual %0h", test, expected, actual);
      stop_run();
    end
  endtask

  task automatic write_reg(input logic [8:0] byte_ofs, input bpl_pkg::word_t value);
    int n;
    n = 0;
    do begin // idle now means the next cycle is enabled
      @(posedge clk);
      n++;
      if (n > 8) begin
        $display("clock enable stuck, write to register %0h never done", byte_ofs);
        stop_run();
      end
    end while (clk7_en !== 1'b0);
    #10;
    reg_address_in = byte_ofs[8:1]; // word address
    data_in        = value;
    @(posedge clk);
    #10;
    reg_address_in = 8'h00;
    data_in        = 16'h0000;
  endtask

  task automatic wait_line(input int line, input int h);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > frame_timeout) begin
        $display("beam never reached line %0d position %0d", line, h);
        stop_run();
      end
    end while (!(vpos == line && hpos == h));
  endtask

  task automatic write_ptr(input int plane, input bpl_pkg::chip_addr_t addr);
    logic [8:0] ofs;
    ofs = `BPL_BPLPTBASE + plane * 4; // high word, low word 2 bytes on
    write_reg(ofs, {11'h000, addr[19:15]});
    write_reg(ofs + 9'd2, {addr[14:0], 1'b0});
  endtask

  // vertical window top_line..end_line-1, fetch window $38..$90
  task automatic setup_window(input int top_line, input int end_line,
                              input bpl_pkg::word_t con0, input int np);
    wait_line(top_line - 3, 0);
    write_reg(`BPL_DIWSTRT, {top_line[7:0], 8'h81});
    write_reg(`BPL_DIWSTOP, {end_line[7:0], 8'hC1});
    write_reg(`BPL_DIWHIGH, 16'h0000); // V10-V8 of both edges zero
    write_reg(`BPL_DDFSTRT, 16'h0038);
    write_reg(`BPL_DDFSTOP, 16'h0090);
    write_reg(`BPL_BPLCON0, con0);
    nplanes = np;
  endtask

  // collects every dma slot of one line
  task automatic scan_line(input int line);
    int n;
    slot_addr.delete();
    slot_plane.delete();
    line_loads = 0;
    n = 0;
    while (vpos != line) begin
      @(negedge clk);
      n++;
      if (n > frame_timeout) begin
        $display("beam never reached line %0d", line);
        stop_run();
      end
    end
    n = 0;
    while (vpos == line) begin
      if (clk7_en && dma) begin
        slot_addr.push_back(address_out);
        slot_plane.push_back(int'(reg_address_out) - int'(`BPL_BPL1DAT));
      end
      if (bpl_load) line_loads++;
      @(negedge clk);
      n++;
      if (n > line_timeout) begin
        $display("line %0d never ended", line);
        stop_run();
      end
    end
  endtask

  // ------------------------------------------------
  // latch monitor
  // ------------------------------------------------
  always @(negedge clk) begin : latch_monitor
    int p;
    if (bpl_load === 1'b1) begin
      load_count++;
      for (p = 0; p < nplanes; p++) begin
        check("latch_load", last_addr[p][15:0] ^ 16'hA5A5, bpl_data[p]);
      end
    end
    p = int'(reg_address_out) - int'(`BPL_BPL1DAT);
    if (clk7_en && dma && p >= 0 && p < 6) begin
      last_addr[p] = address_out;
    end
  end

  // ------------------------------------------------
  // tests
  // ------------------------------------------------
  task automatic reset_idle();
    scan_line(1);
    check("reset_idle", 0, slot_addr.size());
    check("reset_idle", 0, line_loads);
  endtask

  task automatic pointer_step();
    bpl_pkg::chip_addr_t ptr;
    bpl_pkg::chip_addr_t expected;
    setup_window(16, 20, 16'h1000, 1); // 1 plane lowres
    ptr = $urandom;
    write_ptr(0, ptr);
    scan_line(16);
    check("pointer_step", 1, slot_addr.size() > 0);
    expected = ptr;
    foreach (slot_addr[i]) begin
      check("pointer_step", 0, slot_plane[i]);
      check("pointer_step", expected, slot_addr[i]);
      expected = slot_addr[i] + 20'd1;
    end
  endtask

  task automatic modulo();
    bpl_pkg::chip_addr_t last [2];
    bpl_pkg::chip_addr_t expected;
    bpl_pkg::word_t      mod [2];  // byte moduli, BPL1 then BPL2
    int                  seen [2];
    int                  p;
    setup_window(28, 32, 16'h2000, 2); // 2 planes lowres
    mod[0] = $urandom & 16'h01FE;
    mod[1] = $urandom & 16'h01FE;
    write_reg(`BPL_BPL1MOD, mod[0]);
    write_reg(`BPL_BPL2MOD, mod[1]);
    write_ptr(0, $urandom);
    write_ptr(1, $urandom);
    scan_line(28);
    check("modulo", 1, slot_addr.size() > 0);
    foreach (slot_addr[i]) begin
      check("modulo", 1, slot_plane[i] >= 0 && slot_plane[i] < 2);
      last[slot_plane[i]] = slot_addr[i];
    end
    seen = '{0, 0};
    scan_line(29);
    foreach (slot_addr[i]) begin
      p = slot_plane[i];
      check("modulo", 1, p >= 0 && p < 2);
      if (seen[p] == 0) begin
        expected = last[p] + 20'd1 + {4'h0, mod[p] >> 1}; // word step
        check("modulo", expected, slot_addr[i]);
        seen[p] = 1;
      end
    end
    check("modulo", 1, seen[0] == 1 && seen[1] == 1);
  endtask

  task automatic tally_planes(input string test, input int line);
    int per_plane [3];
    int p;
    per_plane = '{0, 0, 0};
    scan_line(line);
    check(test, 1, slot_addr.size() > 0);
    foreach (slot_plane[i]) begin
      p = slot_plane[i];
      check(test, 1, p >= 0 && p < 3); // only BPL1DAT..BPL3DAT
      per_plane[p]++;
    end
    check(test, per_plane[0], per_plane[1]);
    check(test, per_plane[0], per_plane[2]);
  endtask

  task automatic plane_order();
    setup_window(40, 44, 16'h3000, 3); // lowres
    tally_planes("plane_order_lowres", 40);
    setup_window(52, 56, 16'hB000, 3); // hires
    tally_planes("plane_order_hires", 52);
  endtask

  task automatic vertical_window();
    int line;
    setup_window(64, 66, 16'h1000, 1);
    for (line = 63; line < 68; line++) begin
      scan_line(line);
      if (line >= 64 && line < 66) begin
        check("vertical_window", 1, slot_addr.size() > 0);
      end else begin
        check("vertical_window", 0, slot_addr.size());
      end
    end
  endtask

  initial begin
    seed           = 32'h03a03489;
    phase          = $urandom(seed); // seeds the generator
    clk            = 1'b0;
    reset          = 1'b1;
    clk7_en        = phase[0];
    ecs            = 1'b1;
    a1k            = 1'b0;
    dmaena         = 1'b1;
    reg_address_in = 8'h00;
    data_in        = 16'h0000;
    nplanes        = 0;
    load_count     = 0;
    repeat (5) @(posedge clk);
    #10 reset = 1'b0;
    reset_idle();
    pointer_step();
    modulo();
    plane_order();
    vertical_window();
    check("latch_load", 1, load_count > 0);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- build.f
+incdir+include
rtl/bpl_pkg.sv
rtl/beam_counter.sv
rtl/bitplane_dma.sv
rtl/bitplane_latch.sv
rtl/bitplane_fetch_top.sv
tb/tb_bitplane_fetch.sv

//--- Bender.yml
package:
  name: bitplane_fetch

sources:
  - include_dirs:
      - include
    files:
      - rtl/bpl_pkg.sv
      - rtl/beam_counter.sv
      - rtl/bitplane_dma.sv
      - rtl/bitplane_latch.sv
      - rtl/bitplane_fetch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_bitplane_fetch.sv
